/* files.f */
+incdir+tests
hdl/mcu_pwr_pkg.sv
hdl/irq_wake_ctrl.sv
hdl/pwr_domain_seq.sv
hdl/mcu_pwr_top.sv
tests/mcu_pwr_assert.sv
tests/tb_mcu_pwr.sv

/* Makefile */
# Verilator build and run for the MCU power controller testbench

VERILATOR ?= verilator
TOP       ?= tb_mcu_pwr
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary -j 0 --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status follows the pass message in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

/* tests/mcu_pwr_checks.svh */
/*
  typed compare tasks and small stimulus helpers for the power controller testbench;
  included inside the testbench top module, after its signal declarations
*/
`ifndef MCU_PWR_CHECKS_SVH
`define MCU_PWR_CHECKS_SVH

task automatic abort_run();
  fail_reported = 1'b1;
  $display("*** FAILED ***");
  $fatal(1, "stopped at first error in %s", test_name);
endtask

task automatic check_vec(input string what, input irq_vec_t exp, input irq_vec_t act);
  if (act !== exp) begin
    error_count++;
    $display("CHECK FAILED %s/%s: expected %h, actual %h", test_name, what, exp, act);
    abort_run();
  end
endtask

// struct printed in field order pwrgate, iso, rst, clkgate, retentive
task automatic check_pwr(input string what, input pwr_ctrl_t exp, input pwr_ctrl_t act);
  if (act !== exp) begin
    error_count++;
    $display("CHECK FAILED %s/%s: expected %05b, actual %05b", test_name, what, exp, act);
    abort_run();
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    error_count++;
    $display("CHECK FAILED %s/%s: expected %b, actual %b", test_name, what, exp, act);
    abort_run();
  end
endtask

// one clock step, ends where registered outputs are settled
task automatic tick();
  @(posedge clk);
  @(negedge clk);
endtask

// fast line numbering seen by the core
function automatic fast_irq_t fast_lines(input irq_src_t src);
  fast_irq_t f;
  f = '0;
  f[0] = src.timer[1];
  f[1] = src.timer[2];
  f[2] = src.timer[3];
  f[3] = src.dma_done;
  f[4] = src.spi;
  f[5] = src.spi_flash;
  f[13:6] = src.gpio_ao;
  return f;
endfunction

function automatic irq_vec_t expect_intr(input irq_src_t src, input fast_irq_t pend);
  irq_vec_t v;
  v = '0;
  v[IRQ_SOFTWARE_BIT] = src.software;
  v[IRQ_TIMER_BIT] = src.timer[0];
  v[IRQ_EXTERNAL_BIT] = src.external;
  for (int i = 0; i < NUM_FAST_IRQ; i++) begin
    v[FAST_IRQ_BASE + i] = pend[i];
  end
  return v;
endfunction

`endif

/* tests/tb_mcu_pwr.sv */
/*
  directed testbench for the MCU power controller; models the switch acknowledge
  with a random lag and walks the interrupt, wake and power sequencing behavior
*/
`timescale 1ns/1ps

// power switch acknowledge, follows the enable after 2 to 6 cycles
module switch_ack_model (
  input  logic clk_i,
  input  logic pwrgate_en_n_i,
  output logic ack_n_o
);

  int unsigned lag;

  initial begin
    ack_n_o = 1'b1;
    forever begin
      @(posedge clk_i);
      if (pwrgate_en_n_i !== ack_n_o) begin
        lag = 2 + ($urandom % 5);
        repeat (lag - 1) @(posedge clk_i);
        ack_n_o <= pwrgate_en_n_i;
      end
    end
  end

endmodule

module tb_mcu_pwr
  import mcu_pwr_pkg::*;
;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 5;
  localparam int SEED = 23;
  localparam int RAND_ITERS = 24;
  localparam int ACK_WAIT_MAX = 12;
  localparam int SPI_LINE = 4;
  localparam int MAP_CYCLES = RAND_ITERS + NUM_FAST_IRQ + 4;
  localparam int LATCH_CYCLES = 12;
  localparam int SEQ_CYCLES = 12 + 2 * ACK_WAIT_MAX;
  localparam int MEM_CYCLES = 10;
  localparam int TEST_CYCLES = RESET_CYCLES + MAP_CYCLES + LATCH_CYCLES +
                               2 * SEQ_CYCLES + MEM_CYCLES + 4;
  localparam int WATCHDOG_MARGIN = 4;

  logic       clk;
  logic       rst_n;
  irq_src_t   irq_src;
  logic       irq_ack;
  irq_id_t    irq_id;
  logic       core_sleep;
  logic       cpu_sleep_en;
  logic       periph_off;
  bank_mask_t mem_retain;
  logic       cpu_ack_n;
  logic       periph_ack_n;
  irq_vec_t   intr;
  pwr_ctrl_t  cpu_pwr;
  pwr_ctrl_t  periph_pwr;
  pwr_ctrl_t  mem_pwr [NUM_BANKS];

  string test_name = "startup";
  int    error_count = 0;
  bit    passed = 1'b0;
  bit    fail_reported = 1'b0;

  `include "mcu_pwr_checks.svh"

  mcu_pwr_top DUT (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .irq_src_i(irq_src),
    .irq_ack_i(irq_ack),
    .irq_id_i(irq_id),
    .core_sleep_i(core_sleep),
    .cpu_sleep_en_i(cpu_sleep_en),
    .periph_off_i(periph_off),
    .mem_retain_i(mem_retain),
    .cpu_pwr_ack_n_i(cpu_ack_n),
    .periph_pwr_ack_n_i(periph_ack_n),
    .intr_o(intr),
    .cpu_pwr_o(cpu_pwr),
    .periph_pwr_o(periph_pwr),
    .mem_pwr_o(mem_pwr)
  );

  switch_ack_model cpu_ack_i (
    .clk_i(clk),
    .pwrgate_en_n_i(cpu_pwr.pwrgate_en_n),
    .ack_n_o(cpu_ack_n)
  );

  switch_ack_model periph_ack_i (
    .clk_i(clk),
    .pwrgate_en_n_i(periph_pwr.pwrgate_en_n),
    .ack_n_o(periph_ack_n)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic ack_level(input bit cpu_dom);
    return cpu_dom ? cpu_ack_n : periph_ack_n;
  endfunction

  function automatic pwr_ctrl_t domain_pwr(input bit cpu_dom);
    return cpu_dom ? cpu_pwr : periph_pwr;
  endfunction

  // outputs must hold while the switch settles
  task automatic hold_until_ack(input bit cpu_dom, input logic level,
                                input pwr_ctrl_t hold, input string what);
    int n;
    n = 0;
    while (ack_level(cpu_dom) !== level) begin
      check_pwr(what, hold, domain_pwr(cpu_dom));
      if (n == ACK_WAIT_MAX) begin
        $display("switch acknowledge never reached %b in %s", level, test_name);
        abort_run();
      end
      n++;
      tick();
    end
  endtask

  task automatic check_banks(input string what, input pwr_ctrl_t e0, input pwr_ctrl_t e1);
    check_pwr({what, " bank0"}, e0, mem_pwr[0]);
    check_pwr({what, " bank1"}, e1, mem_pwr[1]);
  endtask

  task automatic reset_values();
    test_name = "reset_values";
    @(negedge clk);
    check_vec("intr", '0, intr);
    check_pwr("cpu", '1, cpu_pwr);
    check_pwr("periph", '1, periph_pwr);
    check_banks("mem", '1, '1);
    check_bit("cpu off request", 1'b0, DUT.cpu_off_req);
  endtask

  task automatic intr_mapping();
    fast_irq_t   pend;
    irq_src_t    src;
    logic [31:0] rnd;
    test_name = "intr_mapping";
    pend = '0;
    for (int k = 0; k < RAND_ITERS; k++) begin
      rnd = $urandom();
      src = irq_src_t'(rnd[$bits(irq_src_t)-1:0]);
      @(posedge clk);
      irq_src <= src;
      // pass-through now, fast bits from earlier patterns
      @(negedge clk);
      check_vec("pattern", expect_intr(src, pend), intr);
      pend = pend | fast_lines(src);
    end
    @(posedge clk);
    irq_src <= '0;
    @(negedge clk);
    check_vec("latched", expect_intr('0, pend), intr);
    for (int i = 0; i < NUM_FAST_IRQ; i++) begin
      @(posedge clk);
      irq_ack <= 1'b1;
      irq_id <= irq_id_t'(FAST_IRQ_BASE + i);
    end
    @(posedge clk);
    irq_ack <= 1'b0;
    @(negedge clk);
    check_vec("all acked", '0, intr);
  endtask

  task automatic fast_latch_ack();
    irq_src_t src;
    irq_vec_t exp;
    test_name = "fast_latch_ack";
    src = '0;
    src.spi = 1'b1;
    exp = '0;
    exp[FAST_IRQ_BASE + SPI_LINE] = 1'b1;
    @(posedge clk);
    irq_src <= src;
    @(posedge clk);
    irq_src <= '0;
    @(negedge clk);
    check_vec("set", exp, intr);
    tick();
    check_vec("held after source drop", exp, intr);
    @(posedge clk);
    irq_ack <= 1'b1;
    irq_id <= irq_id_t'(FAST_IRQ_BASE + SPI_LINE + 1);
    @(posedge clk);
    irq_ack <= 1'b0;
    @(negedge clk);
    check_vec("wrong id", exp, intr);
    @(posedge clk);
    irq_ack <= 1'b1;
    irq_id <= irq_id_t'(FAST_IRQ_BASE + SPI_LINE);
    @(negedge clk);
    check_vec("ack not yet seen", exp, intr);
    @(posedge clk);
    irq_ack <= 1'b0;
    @(negedge clk);
    check_vec("acked", '0, intr);
  endtask

  task automatic periph_sequence();
    pwr_ctrl_t e;
    test_name = "periph_sequence";
    e = '1;
    @(posedge clk);
    periph_off <= 1'b1;
    tick();
    e.clkgate_en_n = 1'b0;
    check_pwr("gate clock", e, periph_pwr);
    tick();
    e.isogate_en_n = 1'b0;
    check_pwr("isolate", e, periph_pwr);
    tick();
    e.rst_n = 1'b0;
    check_pwr("assert reset", e, periph_pwr);
    tick();
    e.pwrgate_en_n = 1'b0;
    check_pwr("switch off", e, periph_pwr);
    hold_until_ack(1'b0, 1'b0, e, "wait off ack");
    // OFF is entered on this edge
    @(posedge clk);
    periph_off <= 1'b0;
    @(negedge clk);
    check_pwr("off", e, periph_pwr);
    tick();
    e.pwrgate_en_n = 1'b1;
    check_pwr("switch on", e, periph_pwr);
    hold_until_ack(1'b0, 1'b1, e, "wait on ack");
    tick();
    e.rst_n = 1'b1;
    check_pwr("release reset", e, periph_pwr);
    tick();
    e.isogate_en_n = 1'b1;
    check_pwr("release iso", e, periph_pwr);
    tick();
    e.clkgate_en_n = 1'b1;
    check_pwr("on", e, periph_pwr);
  endtask

  task automatic mem_retention();
    pwr_ctrl_t e;
    test_name = "mem_retention";
    e = '1;
    @(posedge clk);
    mem_retain <= bank_mask_t'(1);
    tick();
    e.clkgate_en_n = 1'b0;
    check_banks("gate clock", e, '1);
    tick();
    e.isogate_en_n = 1'b0;
    check_banks("isolate", e, '1);
    tick();
    e.retentive_en_n = 1'b0;
    check_banks("retain", e, '1);
    tick();
    check_banks("off", e, '1);
    @(posedge clk);
    mem_retain <= '0;
    tick();
    e.retentive_en_n = 1'b1;
    check_banks("leave retention", e, '1);
    tick();
    e.isogate_en_n = 1'b1;
    check_banks("release iso", e, '1);
    tick();
    e.clkgate_en_n = 1'b1;
    check_banks("on", e, '1);
  endtask

  task automatic cpu_sleep_wake();
    pwr_ctrl_t e;
    irq_src_t  src;
    irq_vec_t  exp;
    test_name = "cpu_sleep_wake";
    e = '1;
    src = '0;
    src.timer[0] = 1'b1;
    exp = '0;
    exp[IRQ_TIMER_BIT] = 1'b1;
    @(posedge clk);
    cpu_sleep_en <= 1'b1;
    core_sleep <= 1'b1;
    tick();
    check_bit("sleep request", 1'b1, DUT.cpu_off_req);
    check_pwr("still on", e, cpu_pwr);
    tick();
    e.clkgate_en_n = 1'b0;
    check_pwr("gate clock", e, cpu_pwr);
    tick();
    e.isogate_en_n = 1'b0;
    check_pwr("isolate", e, cpu_pwr);
    tick();
    e.rst_n = 1'b0;
    check_pwr("assert reset", e, cpu_pwr);
    tick();
    e.pwrgate_en_n = 1'b0;
    check_pwr("switch off", e, cpu_pwr);
    hold_until_ack(1'b1, 1'b0, e, "wait off ack");
    @(posedge clk);
    irq_src <= src;
    @(negedge clk);
    check_vec("timer wake", exp, intr);
    check_pwr("off", e, cpu_pwr);
    tick();
    check_bit("wake cancels request", 1'b0, DUT.cpu_off_req);
    check_pwr("still off", e, cpu_pwr);
    tick();
    e.pwrgate_en_n = 1'b1;
    check_pwr("switch on", e, cpu_pwr);
    hold_until_ack(1'b1, 1'b1, e, "wait on ack");
    tick();
    e.rst_n = 1'b1;
    check_pwr("release reset", e, cpu_pwr);
    tick();
    e.isogate_en_n = 1'b1;
    check_pwr("release iso", e, cpu_pwr);
    tick();
    e.clkgate_en_n = 1'b1;
    check_pwr("on", e, cpu_pwr);
    @(posedge clk);
    irq_src <= '0;
    cpu_sleep_en <= 1'b0;
    core_sleep <= 1'b0;
  endtask

  initial begin
    #(TEST_CYCLES * WATCHDOG_MARGIN * CLK_PERIOD);
    $display("watchdog expired before the tests finished, last test %s", test_name);
    abort_run();
  end

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    rst_n = 1'b0;
    irq_src = '0;
    irq_ack = 1'b0;
    irq_id = '0;
    core_sleep = 1'b0;
    cpu_sleep_en = 1'b0;
    periph_off = 1'b0;
    mem_retain = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    reset_values();
    intr_mapping();
    fast_latch_ack();
    periph_sequence();
    mem_retention();
    cpu_sleep_wake();
    if (error_count == 0) begin
      passed = 1'b1;
      $display("*** PASSED ***");
    end else begin
      fail_reported = 1'b1;
      $display("*** FAILED ***");
    end
    $finish;
  end

  // run stopped by an assertion before reaching the end
  final begin
    if (!passed && !fail_reported) begin
      $display("*** FAILED ***");
    end
  end

endmodule

/* tests/mcu_pwr_assert.sv */
/*
  ordering rules on the control outputs of every domain sequencer;
  attached to each pwr_domain_seq instance through bind
*/
`timescale 1ns/1ps

module mcu_pwr_assert
  import mcu_pwr_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input pwr_ctrl_t pwr_ctrl_i
);

  // domain stays in reset while unpowered
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pwr_ctrl_i.rst_n && !pwr_ctrl_i.pwrgate_en_n))
    else $error("reset released while power switch is off");

  // isolation only lifts on a powered domain
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pwr_ctrl_i.pwrgate_en_n |-> !$rose(pwr_ctrl_i.isogate_en_n))
    else $error("isolation released while power switch is off");

endmodule

bind pwr_domain_seq mcu_pwr_assert seq_assert_i (
  .clk_i(clk_i),
  .rst_n_i(rst_n_i),
  .pwr_ctrl_i(pwr_ctrl_o)
);

/* hdl/mcu_pwr_top.sv */
/*
  MCU power controller top level; the interrupt and wake block feeds the
  CPU domain sequencer, peripheral and memory bank sequencers take direct requests
*/
`timescale 1ns/1ps

module mcu_pwr_top
  import mcu_pwr_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  input  irq_src_t   irq_src_i,
  input  logic       irq_ack_i,
  input  irq_id_t    irq_id_i,

  input  logic       core_sleep_i,
  input  logic       cpu_sleep_en_i,
  input  logic       periph_off_i,
  input  bank_mask_t mem_retain_i,

  input  logic       cpu_pwr_ack_n_i,
  input  logic       periph_pwr_ack_n_i,

  output irq_vec_t   intr_o,
  output pwr_ctrl_t  cpu_pwr_o,
  output pwr_ctrl_t  periph_pwr_o,
  output pwr_ctrl_t  mem_pwr_o [NUM_BANKS]
);

  logic cpu_off_req;

  irq_wake_ctrl irq_wake_ctrl_i (
    .clk_i,
    .rst_n_i,
    .irq_src_i,
    .irq_ack_i,
    .irq_id_i,
    .core_sleep_i,
    .cpu_sleep_en_i,
    .intr_o,
    .cpu_off_req_o(cpu_off_req)
  );

  pwr_domain_seq #(
    .RETENTIVE(1'b0)
  ) cpu_pwr_seq_i (
    .clk_i,
    .rst_n_i,
    .off_req_i(cpu_off_req),
    .pwrgate_ack_n_i(cpu_pwr_ack_n_i),
    .pwr_ctrl_o(cpu_pwr_o)
  );

  pwr_domain_seq #(
    .RETENTIVE(1'b0)
  ) periph_pwr_seq_i (
    .clk_i,
    .rst_n_i,
    .off_req_i(periph_off_i),
    .pwrgate_ack_n_i(periph_pwr_ack_n_i),
    .pwr_ctrl_o(periph_pwr_o)
  );

  // banks go retentive, no switch acknowledge
  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_mem_bank
    pwr_domain_seq #(
      .RETENTIVE(1'b1)
    ) mem_pwr_seq_i (
      .clk_i,
      .rst_n_i,
      .off_req_i(mem_retain_i[i]),
      .pwrgate_ack_n_i(1'b1),
      .pwr_ctrl_o(mem_pwr_o[i])
    );
  end

endmodule

/* hdl/pwr_domain_seq.sv */
/*
  power-down and power-up sequencer for one switchable domain;
  RETENTIVE selects a power-switch domain (0) or a retention bank (1)
*/
`timescale 1ns/1ps

module pwr_domain_seq
  import mcu_pwr_pkg::*;
#(
  parameter bit RETENTIVE = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      off_req_i,
  // switch acknowledge, level, active low
  input  logic      pwrgate_ack_n_i,

  output pwr_ctrl_t pwr_ctrl_o
);

  pwr_state_e state_q;
  pwr_state_e state_d;
  pwr_ctrl_t  ctrl_q;

  // control levels held in each state
  function automatic pwr_ctrl_t decode_state(input pwr_state_e st);
    pwr_ctrl_t c;
    c = '1;
    c.clkgate_en_n = (st == ON);
    c.isogate_en_n = (st == ON) || (st == GATE_CLK) || (st == RELEASE_ISO);
    if (RETENTIVE) begin
      c.retentive_en_n = (st != OFF);
    end else begin
      c.pwrgate_en_n = !((st == SWITCH_OFF) || (st == WAIT_OFF_ACK) || (st == OFF));
      c.rst_n = !((st == ASSERT_RST) || (st == SWITCH_OFF) ||
                  (st == WAIT_OFF_ACK) || (st == OFF) ||
                  (st == SWITCH_ON) || (st == WAIT_ON_ACK));
    end
    return c;
  endfunction

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ON: begin
        if (off_req_i) begin
          state_d = GATE_CLK;
        end
      end
      GATE_CLK: begin
        state_d = ISOLATE;
      end
      ISOLATE: begin
        // banks keep their content, no reset and no switch
        state_d = RETENTIVE ? OFF : ASSERT_RST;
      end
      ASSERT_RST: begin
        state_d = SWITCH_OFF;
      end
      SWITCH_OFF: begin
        state_d = WAIT_OFF_ACK;
      end
      WAIT_OFF_ACK: begin
        if (!pwrgate_ack_n_i) begin
          state_d = OFF;
        end
      end
      OFF: begin
        if (!off_req_i) begin
          state_d = RETENTIVE ? RELEASE_RST : SWITCH_ON;
        end
      end
      SWITCH_ON: begin
        state_d = WAIT_ON_ACK;
      end
      WAIT_ON_ACK: begin
        // switch may take any number of cycles
        if (pwrgate_ack_n_i) begin
          state_d = RELEASE_RST;
        end
      end
      RELEASE_RST: begin
        state_d = RELEASE_ISO;
      end
      RELEASE_ISO: begin
        state_d = ON;
      end
      default: begin
        state_d = ON;
      end
    endcase
  end

  // outputs follow the next state so each step lands one cycle after its edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ON;
      ctrl_q <= '1;
    end else begin
      state_q <= state_d;
      ctrl_q <= decode_state(state_d);
    end
  end

  assign pwr_ctrl_o = ctrl_q;

endmodule

/* hdl/irq_wake_ctrl.sv */
/*
  core interrupt vector assembly with fast line latching and ack-by-id clear;
  also raises the registered CPU domain off request while the core sleeps
*/
`timescale 1ns/1ps

module irq_wake_ctrl
  import mcu_pwr_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  irq_src_t irq_src_i,

  input  logic     irq_ack_i,
  input  irq_id_t  irq_id_i,

  input  logic     core_sleep_i,
  input  logic     cpu_sleep_en_i,

  output irq_vec_t intr_o,
  output logic     cpu_off_req_o
);

  fast_irq_t fast_src;
  fast_irq_t fast_clr;
  fast_irq_t fast_pend_q;
  logic      wakeup;
  logic      cpu_off_req_q;

  // fast line order as seen by the core, top line unused
  assign fast_src = {
    1'b0,
    irq_src_i.gpio_ao,
    irq_src_i.spi_flash,
    irq_src_i.spi,
    irq_src_i.dma_done,
    irq_src_i.timer[3],
    irq_src_i.timer[2],
    irq_src_i.timer[1]
  };

  // ack clears only the line whose id the core reports
  always_comb begin
    for (int i = 0; i < NUM_FAST_IRQ; i++) begin
      fast_clr[i] = irq_ack_i && (irq_id_i == irq_id_t'(FAST_IRQ_BASE + i));
    end
  end

  // new source edge wins over a same-cycle ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fast_pend_q <= '0;
    end else begin
      fast_pend_q <= (fast_pend_q & ~fast_clr) | fast_src;
    end
  end

  always_comb begin
    intr_o = '0;
    intr_o[IRQ_SOFTWARE_BIT] = irq_src_i.software;
    intr_o[IRQ_TIMER_BIT] = irq_src_i.timer[0];
    intr_o[IRQ_EXTERNAL_BIT] = irq_src_i.external;
    intr_o[FAST_IRQ_BASE+:NUM_FAST_IRQ] = fast_pend_q;
  end

  assign wakeup = |intr_o;

  // any pending interrupt cancels the sleep request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cpu_off_req_q <= 1'b0;
    end else if (wakeup || !cpu_sleep_en_i) begin
      cpu_off_req_q <= 1'b0;
    end else if (core_sleep_i) begin
      cpu_off_req_q <= 1'b1;
    end
  end

  assign cpu_off_req_o = cpu_off_req_q;

endmodule

/* hdl/mcu_pwr_pkg.sv */
/*
  shared constants, vector types and power control structs for the MCU
  power controller; imported by every RTL module of the project
*/
package mcu_pwr_pkg;

  // switchable sram banks
  localparam int NUM_BANKS = 2;
  localparam int NUM_FAST_IRQ = 15;
  localparam int NUM_GPIO_AO = 8;
  localparam int NUM_TIMERS = 4;

  // core interrupt id of fast line 0
  localparam int FAST_IRQ_BASE = 16;

  localparam int IRQ_SOFTWARE_BIT = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXTERNAL_BIT = 11;

  typedef logic [31:0] irq_vec_t;
  typedef logic [NUM_FAST_IRQ-1:0] fast_irq_t;
  typedef logic [4:0] irq_id_t;
  typedef logic [NUM_GPIO_AO-1:0] gpio_ao_irq_t;
  typedef logic [NUM_TIMERS-1:0] timer_irq_t;
  typedef logic [NUM_BANKS-1:0] bank_mask_t;

  // raw interrupt sources before mapping into the core vector
  typedef struct packed {
    logic software;
    logic external;
    timer_irq_t timer;
    logic dma_done;
    logic spi;
    logic spi_flash;
    gpio_ao_irq_t gpio_ao;
  } irq_src_t;

  // all controls active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_t;

  typedef enum logic [3:0] {
    ON,
    GATE_CLK,
    ISOLATE,
    ASSERT_RST,
    SWITCH_OFF,
    WAIT_OFF_ACK,
    OFF,
    SWITCH_ON,
    WAIT_ON_ACK,
    RELEASE_RST,
    RELEASE_ISO
  } pwr_state_e;

endpackage
